//--- project.f
source/cpuPkg.sv
source/instrDecoder.sv
source/regFile.sv
source/execUnit.sv
source/wbDataPort.sv
source/progSequencer.sv
source/cpuTop.sv
bench/cpuBus_sva.sv
bench/cpuChecker.sv
bench/cpuTb.sv

//--- run.sh
#!/bin/sh
# Build and run the cpuTb simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module cpuTb \
    --Mdir obj_dir -o cpuSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cpuSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

//--- bench/cpuTb.sv
module cpuTb;
    import cpuPkg::*;

    localparam int DATA_W = 8;
    localparam int ROM_N  = 80;
    localparam logic [31:0] SEED = 32'hdbd41a40;

    logic                i_Clk;
    logic                i_arstN;
    logic [INSTR_W-1:0]  i_instrData;
    logic [DATA_W-1:0]   i_wbDatR;
    logic                i_wbAck;
    logic [DATA_W-1:0]   o_instrAddr;
    logic                o_wbCyc;
    logic                o_wbStb;
    logic                o_wbWe;
    logic [DATA_W-1:0]   o_wbAdr;
    logic [DATA_W-1:0]   o_wbDatW;
    logic                o_halted;

    logic [INSTR_W-1:0]  rom [ROM_N];
    logic [7:0]          mem [256];
    int                  romPos;
    logic [31:0]         lcgState;
    int                  waitCnt;
    logic                inCycle;
    int                  modelSteps;
    int                  checkErrors;
    int                  benchErrors;
    int                  cycles;
    int                  limit;

    cpuTop #(.DATA_W(DATA_W)) dut_i (.*);

    cpuChecker #(.ROM_N(ROM_N)) checker_i (
        .i_Clk        (i_Clk),
        .i_arstN      (i_arstN),
        .i_wbCyc      (o_wbCyc),
        .i_wbStb      (o_wbStb),
        .i_wbWe       (o_wbWe),
        .i_wbAdr      (o_wbAdr),
        .i_wbDatW     (o_wbDatW),
        .i_wbAck      (i_wbAck),
        .i_halted     (o_halted),
        .i_rom        (rom),
        .o_modelSteps (modelSteps),
        .o_errCount   (checkErrors)
    );

    bind cpuTop cpuBus_sva busSva_i (
        .i_Clk    (i_Clk),
        .i_arstN  (i_arstN),
        .i_wbAck  (i_wbAck),
        .i_wbCyc  (o_wbCyc),
        .i_wbStb  (o_wbStb),
        .i_wbWe   (o_wbWe),
        .i_wbAdr  (o_wbAdr),
        .i_wbDatW (o_wbDatW),
        .i_halted (o_halted)
    );

    always #10 i_Clk = ~i_Clk;

    // Instruction port with a halt word beyond the program
    assign i_instrData = (int'(o_instrAddr) < ROM_N) ? rom[o_instrAddr] : 9'h1FF;

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Same rule as the reference model's memory
    function automatic logic [7:0] fillPattern(input int a);
        logic [7:0] b;
        b = 8'(a);
        return (b * 8'd37) ^ 8'h5C;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Program builders
    //////////////////////////////////////////////////////////////////////

    task automatic emit(input opcodeT op, input int rx, input int lo);
        rom[romPos] = {op, 3'(rx), 3'(lo)};
        romPos++;
    endtask

    task automatic emitWord(input int value);
        rom[romPos] = {1'b0, 8'(value)};
        romPos++;
    endtask

    task automatic loadImm(input int rx, input int value);
        emit(LoadRxNum, rx, 0);
        emitWord(value);
    endtask

    // Target load and jump, then a marker store that a taken jump skips
    task automatic jumpOver(input int cond, input int markA, input int markB);
        loadImm(6, romPos + 4);
        emit(JumpRxCond, 6, cond);
        emit(StoreARxRy, markA, markB);
    endtask

    task automatic buildProgram();
        int i;
        for (i = 0; i < ROM_N; i++) begin
            rom[i] = {Nop, 6'b000111};
        end
        romPos = 0;
        // Loads, moves, stores
        loadImm(1, 8'h10);
        loadImm(2, 8'hA5);
        emit(MoveRxRy, 3, 2);
        emit(StoreARxRy, 1, 3);
        loadImm(4, 8'h11);
        emit(StoreARxNum, 4, 0);
        emitWord(8'h3C);
        // Load back, then load a filled location
        emit(LoadRxARy, 5, 1);
        emit(StoreARxRy, 4, 5);
        loadImm(6, 8'h80);
        emit(LoadRxARy, 5, 6);
        emit(StoreARxRy, 1, 5);
        // ALU chain against R0
        loadImm(0, 8'hF0);
        loadImm(2, 8'h20);
        emit(MathRxOp, 2, AluAdd);
        emit(StoreARxRy, 1, 2);
        emit(MathRxOp, 2, AluSub);
        emit(StoreARxRy, 1, 2);
        emit(MathRxOp, 2, AluAnd);
        emit(MathRxOp, 2, AluOr);
        emit(MathRxOp, 2, AluXor);
        emit(StoreARxRy, 1, 2);
        loadImm(3, 8'h81);
        emit(MathRxOp, 3, AluShl);
        emit(MathRxOp, 3, AluShr);
        emit(MathRxOp, 3, AluInc);
        emit(StoreARxRy, 1, 3);
        // Zero and carry both set by the wrap
        loadImm(2, 8'hFF);
        emit(MathRxOp, 2, AluInc);
        jumpOver(JmpZero, 1, 1);
        jumpOver(JmpNotZero, 4, 6);
        jumpOver(JmpCarry, 4, 4);
        jumpOver(JmpNotCarry, 4, 1);
        jumpOver(5, 1, 4);
        jumpOver(JmpLink, 1, 6);
        // Reserved NOP field, then R7 out
        emit(Nop, 0, 3);
        emit(StoreARxRy, 1, 7);
        emit(Nop, 0, 7);
        emit(StoreARxRy, 1, 1);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Wishbone memory model
    //////////////////////////////////////////////////////////////////////

    always @(negedge i_Clk) begin
        if (i_wbAck) begin
            i_wbAck = 1'b0;
        end else if (o_wbCyc && o_wbStb) begin
            if (!inCycle) begin
                inCycle  = 1'b1;
                lcgState = lcgNext(lcgState);
                waitCnt  = int'(lcgState[25:24]);
            end
            if (waitCnt == 0) begin
                i_wbAck = 1'b1;
                inCycle = 1'b0;
                if (o_wbWe) begin
                    mem[o_wbAdr] = o_wbDatW;
                end else begin
                    i_wbDatR = mem[o_wbAdr];
                end
            end else begin
                waitCnt--;
            end
        end
    end

    initial begin
        i_Clk       = 1'b0;
        i_arstN     = 1'b0;
        i_wbAck     = 1'b0;
        i_wbDatR    = '0;
        lcgState    = SEED;
        inCycle     = 1'b0;
        waitCnt     = 0;
        benchErrors = 0;
        for (int a = 0; a < 256; a++) begin
            mem[a] = fillPattern(a);
        end
        buildProgram();
        // Reset over four rising edges, released on a falling edge
        repeat (4) @(posedge i_Clk);
        @(negedge i_Clk);
        i_arstN = 1'b1;
        @(posedge i_Clk);
        limit  = 40 * modelSteps;
        cycles = 0;
        while (!o_halted && cycles < limit) begin
            @(posedge i_Clk);
            cycles++;
        end
        if (!o_halted) begin
            $display("Timeout: the core did not halt within %0d cycles", limit);
            benchErrors++;
        end
        // Let the checker see the halted core for a while
        repeat (8) @(posedge i_Clk);
        $display("Errors: %0d checker, %0d bench", checkErrors, benchErrors);
        if (checkErrors == 0 && benchErrors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- bench/cpuChecker.sv
module cpuChecker #(
    parameter int ROM_N = 80
) (
    input  logic       i_Clk,
    input  logic       i_arstN,
    input  logic       i_wbCyc,
    input  logic       i_wbStb,
    input  logic       i_wbWe,
    input  logic [7:0] i_wbAdr,
    input  logic [7:0] i_wbDatW,
    input  logic       i_wbAck,
    input  logic       i_halted,
    input  logic [8:0] i_rom [ROM_N],
    output int         o_modelSteps,
    output int         o_errCount
);
    import cpuPkg::*;

    logic [7:0] expAdr [$];
    logic [7:0] expDat [$];
    logic       modelHalted;
    logic       modelReady;
    logic       haltSeen;
    logic       lateFlagged;
    int         writeIdx;
    logic [7:0] wantAdr;
    logic [7:0] wantDat;

    function automatic logic [7:0] fillPattern(input int a);
        logic [7:0] b;
        b = 8'(a);
        return (b * 8'd37) ^ 8'h5C;
    endfunction

    function automatic logic [8:0] romWord(input int a);
        return (a < ROM_N) ? i_rom[a] : 9'h1FF;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // ISA reference model
    //////////////////////////////////////////////////////////////////////

    function automatic int runModel();
        logic [7:0] regs [8];
        logic [7:0] mem [256];
        logic       z;
        logic       c;
        logic       take;
        int         pc;
        int         steps;
        logic [8:0] w;
        logic [8:0] wide;
        logic [7:0] a;
        logic [7:0] imm;
        int         rx;
        int         lo;
        for (int i = 0; i < 256; i++) begin
            mem[i] = fillPattern(i);
        end
        for (int i = 0; i < 8; i++) begin
            regs[i] = '0;
        end
        z = 1'b0;
        c = 1'b0;
        pc = 0;
        steps = 0;
        modelHalted = 1'b0;
        while (!modelHalted && steps < 1000) begin
            w     = romWord(pc);
            rx    = int'(w[5:3]);
            lo    = int'(w[2:0]);
            imm   = 8'(romWord((pc + 1) % 256));
            steps++;
            case (opcodeT'(w[8:6]))
                LoadRxNum: begin
                    regs[rx] = imm;
                    pc += 2;
                end
                LoadRxARy: begin
                    regs[rx] = mem[regs[lo]];
                    pc += 1;
                end
                StoreARxNum: begin
                    expAdr.push_back(regs[rx]);
                    expDat.push_back(imm);
                    mem[regs[rx]] = imm;
                    pc += 2;
                end
                StoreARxRy: begin
                    expAdr.push_back(regs[rx]);
                    expDat.push_back(regs[lo]);
                    mem[regs[rx]] = regs[lo];
                    pc += 1;
                end
                MoveRxRy: begin
                    regs[rx] = regs[lo];
                    pc += 1;
                end
                MathRxOp: begin
                    a = regs[rx];
                    case (lo)
                        0: wide = {1'b0, a} + {1'b0, regs[0]};
                        1: wide = {1'b0, a} - {1'b0, regs[0]};
                        2: wide = {1'b0, a & regs[0]};
                        3: wide = {1'b0, a | regs[0]};
                        4: wide = {1'b0, a ^ regs[0]};
                        5: wide = {1'b0, a} << 1;
                        6: wide = {a[0], a >> 1};
                        default: wide = {1'b0, a} + 9'd1;
                    endcase
                    regs[rx] = wide[7:0];
                    z = (wide[7:0] == 8'h00);
                    c = wide[8];
                    pc += 1;
                end
                JumpRxCond: begin
                    a = regs[rx];
                    case (lo)
                        0: take = z;
                        1: take = 1'b1;
                        2: take = !z;
                        3: take = c;
                        4: take = !c;
                        default: take = 1'b0;
                    endcase
                    if (lo == 1) begin
                        regs[7] = 8'(pc + 1);
                    end
                    pc = take ? int'(a) : pc + 1;
                end
                default: begin
                    modelHalted = (lo == 7);
                    pc += 1;
                end
            endcase
            pc = pc % 256;
        end
        return steps;
    endfunction

    initial begin
        o_errCount  = 0;
        modelReady  = 1'b0;
        haltSeen    = 1'b0;
        lateFlagged = 1'b0;
        writeIdx    = 0;
        @(posedge i_arstN);
        o_modelSteps = runModel();
        modelReady   = 1'b1;
    end

    //////////////////////////////////////////////////////////////////////
    // Compare observed bus traffic
    //////////////////////////////////////////////////////////////////////

    always @(posedge i_Clk) begin
        if (i_arstN && modelReady) begin
            if (i_wbCyc && i_wbStb && i_wbAck && i_wbWe) begin
                if (expAdr.size() == 0) begin
                    $display("Extra bus write to %02h with data %02h", i_wbAdr, i_wbDatW);
                    o_errCount++;
                end else begin
                    wantAdr = expAdr.pop_front();
                    wantDat = expDat.pop_front();
                    if (wantAdr !== i_wbAdr || wantDat !== i_wbDatW) begin
                        $display("FAIL bus write %0d expected %02h:%02h actual %02h:%02h",
                                 writeIdx, wantAdr, wantDat, i_wbAdr, i_wbDatW);
                        o_errCount++;
                    end
                end
                writeIdx++;
            end
            if (i_halted && !haltSeen) begin
                haltSeen = 1'b1;
                if (!modelHalted) begin
                    $display("Core halted but the model program never reaches a halt");
                    o_errCount++;
                end
                if (expAdr.size() != 0) begin
                    $display("Core halted with %0d expected writes missing", expAdr.size());
                    o_errCount++;
                end
            end
            // No new bus cycle after halt
            if (haltSeen && i_wbCyc && !lateFlagged) begin
                lateFlagged = 1'b1;
                $display("A bus cycle started after the core halted");
                o_errCount++;
            end
        end
    end

endmodule

//--- bench/cpuBus_sva.sv
module cpuBus_sva (
    input logic       i_Clk,
    input logic       i_arstN,
    input logic       i_wbAck,
    input logic       i_wbCyc,
    input logic       i_wbStb,
    input logic       i_wbWe,
    input logic [7:0] i_wbAdr,
    input logic [7:0] i_wbDatW,
    input logic       i_halted
);

    // Strobe only inside a cycle
    stbInCyc: assert property (@(posedge i_Clk) disable iff (!i_arstN)
        i_wbStb |-> i_wbCyc)
        else $error("stb high without cyc");

    // Request held until the slave acks
    reqStable: assert property (@(posedge i_Clk) disable iff (!i_arstN)
        (i_wbStb && !i_wbAck) |=> (i_wbStb && $stable(i_wbAdr) && $stable(i_wbWe)
                                  && $stable(i_wbDatW)))
        else $error("bus request changed before ack");

    haltSticky: assert property (@(posedge i_Clk) disable iff (!i_arstN)
        i_halted |=> i_halted)
        else $error("halted flag fell");

    cycIdleAfterReset: assert property (@(posedge i_Clk)
        $rose(i_arstN) |-> !i_wbCyc)
        else $error("cyc high right after reset");

endmodule

//--- source/cpuTop.sv
module cpuTop #(
    parameter int DATA_W = 8
) (
    input  logic                       i_Clk,
    input  logic                       i_arstN,
    input  logic [cpuPkg::INSTR_W-1:0] i_instrData,
    input  logic [DATA_W-1:0]          i_wbDatR,
    input  logic                       i_wbAck,
    output logic [DATA_W-1:0]          o_instrAddr,
    output logic                       o_wbCyc,
    output logic                       o_wbStb,
    output logic                       o_wbWe,
    output logic [DATA_W-1:0]          o_wbAdr,
    output logic [DATA_W-1:0]          o_wbDatW,
    output logic                       o_halted
);
    import cpuPkg::*;

    ctrlT               ctrl;
    seqStateT           state;
    memReqT             memReq;
    logic               memReqValid;
    logic               memDone;
    logic [INSTR_W-1:0] instr;
    logic [DATA_W-1:0]  imm;
    logic [DATA_W-1:0]  opA;
    logic [DATA_W-1:0]  opB;
    logic [DATA_W-1:0]  rdData;
    logic [DATA_W-1:0]  linkPc;
    logic               wrEn;
    logic [DATA_W-1:0]  wrData;
    logic               jumpTaken;
    logic [DATA_W-1:0]  jumpTarget;

    //////////////////////////////////////////////////////////////////////
    // Fetch and decode
    //////////////////////////////////////////////////////////////////////

    progSequencer #(.DATA_W(DATA_W)) sequencer_i (
        .i_Clk         (i_Clk),
        .i_arstN       (i_arstN),
        .i_instrData   (i_instrData),
        .i_ctrl        (ctrl),
        .i_jumpTaken   (jumpTaken),
        .i_jumpTarget  (jumpTarget),
        .i_memDone     (memDone),
        .i_regB        (opB),
        .o_instrAddr   (o_instrAddr),
        .o_instr       (instr),
        .o_imm         (imm),
        .o_state       (state),
        .o_memReq      (memReq),
        .o_memReqValid (memReqValid),
        .o_linkPc      (linkPc),
        .o_halted      (o_halted)
    );

    instrDecoder decoder_i (
        .i_instr (instr),
        .o_ctrl  (ctrl)
    );

    //////////////////////////////////////////////////////////////////////
    // Registers, execute and bus
    //////////////////////////////////////////////////////////////////////

    regFile #(.DATA_W(DATA_W)) regFile_i (
        .i_Clk     (i_Clk),
        .i_arstN   (i_arstN),
        .i_rdSelA  (ctrl.regA),
        .i_rdSelB  (ctrl.regB),
        .i_wrSel   (ctrl.regW),
        .i_wrEn    (wrEn),
        .i_wrData  (wrData),
        .o_rdDataA (opA),
        .o_rdDataB (opB)
    );

    execUnit #(.DATA_W(DATA_W)) execUnit_i (
        .i_Clk        (i_Clk),
        .i_arstN      (i_arstN),
        .i_ctrl       (ctrl),
        .i_state      (state),
        .i_opA        (opA),
        .i_opB        (opB),
        .i_imm        (imm),
        .i_memData    (rdData),
        .i_memDone    (memDone),
        .i_linkPc     (linkPc),
        .o_wrEn       (wrEn),
        .o_wrData     (wrData),
        .o_jumpTaken  (jumpTaken),
        .o_jumpTarget (jumpTarget)
    );

    // Data memory master
    wbDataPort #(.DATA_W(DATA_W)) wbPort_i (
        .i_Clk      (i_Clk),
        .i_arstN    (i_arstN),
        .i_req      (memReq),
        .i_reqValid (memReqValid),
        .i_wbDatR   (i_wbDatR),
        .i_wbAck    (i_wbAck),
        .o_wbCyc    (o_wbCyc),
        .o_wbStb    (o_wbStb),
        .o_wbWe     (o_wbWe),
        .o_wbAdr    (o_wbAdr),
        .o_wbDatW   (o_wbDatW),
        .o_rdData   (rdData),
        .o_done     (memDone)
    );

endmodule

//--- source/progSequencer.sv
module progSequencer #(
    parameter int DATA_W = 8
) (
    input  logic                       i_Clk,
    input  logic                       i_arstN,
    input  logic [cpuPkg::INSTR_W-1:0] i_instrData,
    input  cpuPkg::ctrlT               i_ctrl,
    input  logic                       i_jumpTaken,
    input  logic [DATA_W-1:0]          i_jumpTarget,
    input  logic                       i_memDone,
    input  logic [DATA_W-1:0]          i_regB,
    output logic [DATA_W-1:0]          o_instrAddr,
    output logic [cpuPkg::INSTR_W-1:0] o_instr,
    output logic [DATA_W-1:0]          o_imm,
    output cpuPkg::seqStateT           o_state,
    output cpuPkg::memReqT             o_memReq,
    output logic                       o_memReqValid,
    output logic [DATA_W-1:0]          o_linkPc,
    output logic                       o_halted
);
    import cpuPkg::*;

    // Plain NOP loaded into the instruction register on reset
    localparam logic [INSTR_W-1:0] NopWord = {Nop, 6'b000000};

    seqStateT           stateQ;
    seqStateT           stateNext;
    logic [DATA_W-1:0]  pcQ;
    logic [INSTR_W-1:0] instrQ;
    logic [DATA_W-1:0]  immQ;
    logic               memOp;
    logic               twoWord;

    assign memOp   = i_ctrl.memRd || i_ctrl.memWr;
    // Word on the port during Fetch decides on an extra FetchImm
    assign twoWord = (opcodeT'(i_instrData[8:6]) == LoadRxNum)
                  || (opcodeT'(i_instrData[8:6]) == StoreARxNum);

    //////////////////////////////////////////////////////////////////////
    // State machine
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        stateNext = stateQ;
        case (stateQ)
            Fetch:    stateNext = twoWord ? FetchImm : Exec;
            FetchImm: stateNext = Exec;
            Exec: begin
                if (i_ctrl.halt) begin
                    stateNext = Halted;
                end else if (memOp) begin
                    stateNext = MemWait;
                end else begin
                    stateNext = Fetch;
                end
            end
            // Slave holds off ack as long as it likes
            MemWait:  stateNext = i_memDone ? Fetch : MemWait;
            Halted:   stateNext = Halted;
            default:  stateNext = Fetch;
        endcase
    end

    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            stateQ <= Fetch;
            pcQ    <= '0;
            instrQ <= NopWord;
        end else begin
            stateQ <= stateNext;
            case (stateQ)
                Fetch: begin
                    instrQ <= i_instrData;
                    pcQ    <= pcQ + 1'b1;
                end
                FetchImm: pcQ <= pcQ + 1'b1;
                Exec: begin
                    if (i_jumpTaken) begin
                        pcQ <= i_jumpTarget;
                    end
                end
                default: pcQ <= pcQ;
            endcase
        end
    end

    // Immediate is the low byte of the second word
    always_ff @(posedge i_Clk) begin
        if (stateQ == FetchImm) begin
            immQ <= i_instrData[DATA_W-1:0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Memory request and outputs
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        o_memReq.we  = i_ctrl.memWr;
        o_memReq.adr = i_jumpTarget;
        // StoreARxNum writes the immediate, StoreARxRy writes Ry
        o_memReq.dat = i_ctrl.needImm ? immQ : i_regB;
    end

    // One-cycle pulse in Exec
    assign o_memReqValid = (stateQ == Exec) && memOp;

    assign o_instrAddr = pcQ;
    assign o_instr     = instrQ;
    assign o_imm       = immQ;
    assign o_state     = stateQ;
    // PC already points past the jump word in Exec
    assign o_linkPc    = pcQ;
    assign o_halted    = (stateQ == Halted);

endmodule

//--- source/wbDataPort.sv
module wbDataPort #(
    parameter int DATA_W = 8
) (
    input  logic              i_Clk,
    input  logic              i_arstN,
    input  cpuPkg::memReqT    i_req,
    input  logic              i_reqValid,
    input  logic [DATA_W-1:0] i_wbDatR,
    input  logic              i_wbAck,
    output logic              o_wbCyc,
    output logic              o_wbStb,
    output logic              o_wbWe,
    output logic [DATA_W-1:0] o_wbAdr,
    output logic [DATA_W-1:0] o_wbDatW,
    output logic [DATA_W-1:0] o_rdData,
    output logic              o_done
);

    logic              busyQ;
    logic              weQ;
    logic [DATA_W-1:0] adrQ;
    logic [DATA_W-1:0] datQ;
    logic              ackSeen;
    logic              startReq;

    // Ack only counts inside an open cycle
    assign ackSeen  = busyQ && i_wbAck;
    assign startReq = i_reqValid && !busyQ;

    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            busyQ <= 1'b0;
            weQ   <= 1'b0;
        end else if (ackSeen) begin
            busyQ <= 1'b0;
            weQ   <= 1'b0;
        end else if (startReq) begin
            busyQ <= 1'b1;
            weQ   <= i_req.we;
        end
    end

    // Address and data held until ack
    always_ff @(posedge i_Clk) begin
        if (startReq) begin
            adrQ <= i_req.adr;
            datQ <= i_req.dat;
        end
        if (ackSeen && !weQ) begin
            o_rdData <= i_wbDatR;
        end
    end

    // Classic cycle, cyc and stb move together
    assign o_wbCyc  = busyQ;
    assign o_wbStb  = busyQ;
    assign o_wbWe   = weQ;
    assign o_wbAdr  = adrQ;
    assign o_wbDatW = datQ;
    assign o_done   = ackSeen;

endmodule

//--- source/execUnit.sv
module execUnit #(
    parameter int DATA_W = 8
) (
    input  logic              i_Clk,
    input  logic              i_arstN,
    input  cpuPkg::ctrlT      i_ctrl,
    input  cpuPkg::seqStateT  i_state,
    input  logic [DATA_W-1:0] i_opA,
    input  logic [DATA_W-1:0] i_opB,
    input  logic [DATA_W-1:0] i_imm,
    input  logic [DATA_W-1:0] i_memData,
    input  logic              i_memDone,
    input  logic [DATA_W-1:0] i_linkPc,
    output logic              o_wrEn,
    output logic [DATA_W-1:0] o_wrData,
    output logic              o_jumpTaken,
    output logic [DATA_W-1:0] o_jumpTarget
);
    import cpuPkg::*;

    logic [DATA_W:0] aluRes;
    logic            zeroQ;
    logic            carryQ;
    logic            loadDoneQ;
    logic            mathExec;
    logic            condMet;

    //////////////////////////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////////////////////////

    // Top bit is carry out, or borrow for sub
    always_comb begin
        case (i_ctrl.aluOp)
            AluAdd:  aluRes = {1'b0, i_opA} + {1'b0, i_opB};
            AluSub:  aluRes = {1'b0, i_opA} - {1'b0, i_opB};
            AluAnd:  aluRes = {1'b0, i_opA & i_opB};
            AluOr:   aluRes = {1'b0, i_opA | i_opB};
            AluXor:  aluRes = {1'b0, i_opA ^ i_opB};
            AluShl:  aluRes = {i_opA, 1'b0};
            // Shifted-out bit lands in carry
            AluShr:  aluRes = {i_opA[0], 1'b0, i_opA[DATA_W-1:1]};
            AluInc:  aluRes = {1'b0, i_opA} + 1'b1;
            default: aluRes = '0;
        endcase
    end

    // Only math instructions touch the flags
    assign mathExec = (i_state == Exec) && i_ctrl.regWe && (i_ctrl.wbSrc == WbAlu);

    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            zeroQ     <= 1'b0;
            carryQ    <= 1'b0;
            loadDoneQ <= 1'b0;
        end else begin
            // Load data is registered by the bus port on done
            loadDoneQ <= i_memDone && i_ctrl.memRd;
            if (mathExec) begin
                zeroQ  <= (aluRes[DATA_W-1:0] == '0);
                carryQ <= aluRes[DATA_W];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Write-back and jump
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (i_ctrl.linkWr) begin
            o_wrData = i_linkPc;
        end else begin
            case (i_ctrl.wbSrc)
                WbImm:   o_wrData = i_imm;
                WbMem:   o_wrData = i_memData;
                WbRy:    o_wrData = i_opB;
                default: o_wrData = aluRes[DATA_W-1:0];
            endcase
        end
    end

    // Loads write one cycle after done, everything else in Exec
    assign o_wrEn = i_ctrl.regWe && (loadDoneQ || ((i_state == Exec) && !i_ctrl.memRd));

    always_comb begin
        case (i_ctrl.jumpCond)
            JmpZero:     condMet = zeroQ;
            JmpLink:     condMet = 1'b1;
            JmpNotZero:  condMet = !zeroQ;
            JmpCarry:    condMet = carryQ;
            JmpNotCarry: condMet = !carryQ;
            default:     condMet = 1'b0;
        endcase
    end

    assign o_jumpTaken  = i_ctrl.jumpEn && condMet;
    // Port A is the target, also used as the memory address
    assign o_jumpTarget = i_opA;

endmodule

//--- source/regFile.sv
module regFile #(
    parameter int DATA_W = 8
) (
    input  logic              i_Clk,
    input  logic              i_arstN,
    input  logic [2:0]        i_rdSelA,
    input  logic [2:0]        i_rdSelB,
    input  logic [2:0]        i_wrSel,
    input  logic              i_wrEn,
    input  logic [DATA_W-1:0] i_wrData,
    output logic [DATA_W-1:0] o_rdDataA,
    output logic [DATA_W-1:0] o_rdDataB
);

    // R0..R7, R7 also holds the link address
    logic [DATA_W-1:0] regs [8];

    // Single write port
    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wrEn) begin
            regs[i_wrSel] <= i_wrData;
        end
    end

    // Reads see the old value during a write cycle
    assign o_rdDataA = regs[i_rdSelA];
    assign o_rdDataB = regs[i_rdSelB];

endmodule

//--- source/instrDecoder.sv
module instrDecoder (
    input  logic [cpuPkg::INSTR_W-1:0] i_instr,
    output cpuPkg::ctrlT               o_ctrl
);
    import cpuPkg::*;

    opcodeT     opcode;
    logic [2:0] rx;
    logic [2:0] fieldLo;

    // Instruction fields
    assign opcode  = opcodeT'(i_instr[8:6]);
    assign rx      = i_instr[5:3];
    assign fieldLo = i_instr[2:0];

    always_comb begin
        // All quiet by default, same as a plain NOP
        o_ctrl = '0;
        case (opcode)
            LoadRxNum: begin
                o_ctrl.regW    = rx;
                o_ctrl.regWe   = 1'b1;
                o_ctrl.wbSrc   = WbImm;
                o_ctrl.needImm = 1'b1;
            end
            LoadRxARy: begin
                // Ry goes out on port A as the address
                o_ctrl.regA  = fieldLo;
                o_ctrl.regW  = rx;
                o_ctrl.regWe = 1'b1;
                o_ctrl.wbSrc = WbMem;
                o_ctrl.memRd = 1'b1;
            end
            StoreARxNum: begin
                o_ctrl.regA    = rx;
                o_ctrl.memWr   = 1'b1;
                o_ctrl.needImm = 1'b1;
            end
            StoreARxRy: begin
                // Rx is the address, Ry the data
                o_ctrl.regA  = rx;
                o_ctrl.regB  = fieldLo;
                o_ctrl.memWr = 1'b1;
            end
            MoveRxRy: begin
                o_ctrl.regA  = rx;
                o_ctrl.regB  = fieldLo;
                o_ctrl.regW  = rx;
                o_ctrl.regWe = 1'b1;
                o_ctrl.wbSrc = WbRy;
            end
            MathRxOp: begin
                // Rx op R0 back into Rx
                o_ctrl.regA  = rx;
                o_ctrl.regB  = 3'b000;
                o_ctrl.regW  = rx;
                o_ctrl.regWe = 1'b1;
                o_ctrl.wbSrc = WbAlu;
                o_ctrl.aluOp = aluOpT'(fieldLo);
            end
            JumpRxCond: begin
                o_ctrl.regA     = rx;
                o_ctrl.jumpEn   = 1'b1;
                o_ctrl.jumpCond = jumpCondT'(fieldLo);
                // Linking jump saves the return address in R7
                if (fieldLo == JmpLink) begin
                    o_ctrl.linkWr = 1'b1;
                    o_ctrl.regWe  = 1'b1;
                    o_ctrl.regW   = 3'd7;
                end
            end
            Nop: begin
                o_ctrl.halt = (fieldLo == 3'b111);
            end
            default: begin
                o_ctrl = '0;
            end
        endcase
    end

endmodule

//--- source/cpuPkg.sv
package cpuPkg;

    // Opcode in bits 8..6, Rx in 5..3, Ry or Op or Cond in 2..0
    localparam int INSTR_W = 9;

    // Address and data width of a memory request
    localparam int MEM_W = 8;

    typedef enum logic [2:0] {
        LoadRxNum   = 3'b000,
        LoadRxARy   = 3'b001,
        StoreARxNum = 3'b010,
        StoreARxRy  = 3'b011,
        MoveRxRy    = 3'b100,
        MathRxOp    = 3'b101,
        JumpRxCond  = 3'b110,
        Nop         = 3'b111
    } opcodeT;

    typedef enum logic [2:0] {
        AluAdd = 3'b000,
        AluSub = 3'b001,
        AluAnd = 3'b010,
        AluOr  = 3'b011,
        AluXor = 3'b100,
        AluShl = 3'b101,
        AluShr = 3'b110,
        AluInc = 3'b111
    } aluOpT;

    // Codes 101 and up never jump
    typedef enum logic [2:0] {
        JmpZero     = 3'b000,
        JmpLink     = 3'b001,
        JmpNotZero  = 3'b010,
        JmpCarry    = 3'b011,
        JmpNotCarry = 3'b100
    } jumpCondT;

    // Register write-back source
    typedef enum logic [1:0] {
        WbImm = 2'b00,
        WbMem = 2'b01,
        WbRy  = 2'b10,
        WbAlu = 2'b11
    } wbSrcT;

    // Decoded control word
    typedef struct packed {
        logic [2:0] regA;
        logic [2:0] regB;
        logic [2:0] regW;
        logic       regWe;
        wbSrcT      wbSrc;
        aluOpT      aluOp;
        logic       jumpEn;
        jumpCondT   jumpCond;
        logic       linkWr;
        logic       memRd;
        logic       memWr;
        logic       needImm;
        logic       halt;
    } ctrlT;

    // Request from sequencer to bus port
    typedef struct packed {
        logic             we;
        logic [MEM_W-1:0] adr;
        logic [MEM_W-1:0] dat;
    } memReqT;

    typedef enum logic [2:0] {
        Fetch    = 3'b000,
        FetchImm = 3'b001,
        Exec     = 3'b010,
        MemWait  = 3'b011,
        Halted   = 3'b100
    } seqStateT;

endpackage
